//--- verilog/main_map_pkg.sv
/*
 * Main CPU memory map
 * Address and data widths, region windows of the 16-bit map,
 * banked ROM geometry and the region type shared by the bus blocks
 */
package main_map_pkg;

    localparam int ADDR_W = 16;                    // CPU address bus
    localparam int DATA_W = 8;                     // CPU data bus

    localparam logic [DATA_W-1:0] OPEN_BUS = '1;   // Unmapped reads float high

    // Windows on A[15:10]
    localparam logic [5:0] IO_PAGE  = 6'b0000_00;  // 0000-03FF
    localparam logic [5:0] PAL_PAGE = 6'b0000_11;  // 0C00-0FFF

    // Windows on A[15:12]
    localparam logic [3:0] RAM_PAGE  = 4'h1;       // 1000-1FFF
    localparam logic [3:0] BANK_PAGE = 4'h7;       // Bank register, writes only

    // Windows on A[15:13]
    localparam logic [2:0] GFX1_VRAM_PAGE = 3'b001; // 2000-3FFF
    localparam logic [2:0] GFX2_VRAM_PAGE = 3'b010; // 4000-5FFF
    localparam logic [2:0] BANKED_PAGE    = 3'b011; // 6000-7FFF reads

    // I/O page rows on A[7:3]
    localparam logic [4:0] GFX1_CFG_ROW = 5'b00000; // 00-07
    localparam logic [4:0] OUT_ROW      = 5'b00011; // 18-1F
    localparam logic [4:0] GFX2_CFG_ROW = 5'b01100; // 60-67

    localparam int BANK_OFS_W = 13;                // Offset inside a ROM bank
    localparam int DIRECT_W   = 15;                // Top half maps straight through
    localparam int BANK_BASE  = 4;                 // First banked page sits after the fixed 32kB

    typedef enum logic [3:0] {
        ROM, RAM, PAL, GFX1_VRAM, GFX2_VRAM, GFX1_CFG, GFX2_CFG,
        IN, OUT, BANK, NONE
    } region_t;

endpackage

//--- verilog/cabinet_pkg.sv
/*
 * Cabinet I/O definitions
 * Input port offsets on the I/O page, output register
 * offsets and the joystick record
 */
package cabinet_pkg;

    // Input ports, selected by A[2:0]
    localparam logic [2:0] IN_SYS  = 3'd0;   // Start, service, coins
    localparam logic [2:0] IN_P1   = 3'd1;
    localparam logic [2:0] IN_P2   = 3'd2;
    localparam logic [2:0] IN_DSWA = 3'd4;
    localparam logic [2:0] IN_DSWB = 3'd5;
    localparam logic [2:0] IN_DSWC = 3'd6;   // Only four switches fitted

    // Output registers, selected by A[2:1]
    // 0 is the coin counters and 3 the watchdog, neither kept here
    localparam logic [1:0] OUT_SND_IRQ   = 2'd1;
    localparam logic [1:0] OUT_SND_LATCH = 2'd2;

    typedef struct packed {
        logic [1:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;    // Bit 0
    } joy_t;

endpackage

//--- verilog/cpu_bus_if.sv
/*
 * Internal CPU bus
 * Latched access from the bus controller, decoded region back
 * from the address decoder, read-only view for the I/O blocks
 */
`timescale 1ns/1ps

interface cpu_bus_if import main_map_pkg::*; (input logic clk);

    logic [ADDR_W-1:0] addr;      // Latched CPU address
    logic              rnw;       // High for reads
    logic [DATA_W-1:0] wdata;     // Latched write data
    logic              strobe;    // One cycle, access happens now
    region_t           region;    // Decode of addr and rnw

    modport ctrl (
        output addr, rnw, wdata, strobe,
        input  region
    );

    modport dec (
        input  clk,               // Only for checks
        input  addr, rnw,
        output region
    );

    // Sampling blocks, register on strobe
    modport io (
        input  addr, wdata, strobe, region
    );

endinterface

//--- verilog/addr_decoder.sv
/*
 * Main CPU address decoder
 * Region decode in the priority of the original map, chip selects
 * gated by the active access phase and the banked ROM address
 */
`timescale 1ns/1ps

module addr_decoder import main_map_pkg::*; #(
    parameter int ROM_AW = 17
) (
    cpu_bus_if.dec                          bus,
    input  logic                            active,   // Access phase, from controller
    input  logic [ROM_AW-BANK_OFS_W-1:0]    bank,
    output logic [ROM_AW-1:0]               rom_addr,
    output logic                            rom_cs,
    output logic                            ram_cs,
    output logic                            pal_cs,
    output logic                            gfx1_vram_cs,
    output logic                            gfx2_vram_cs,
    output logic                            gfx1_cfg_cs,
    output logic                            gfx2_cfg_cs
);

    localparam int BANK_W = ROM_AW - BANK_OFS_W;

    logic [ADDR_W-1:0] a;
    assign a = bus.addr;

    always_comb begin
        if ((a[15] || a[15:13] == BANKED_PAGE) && bus.rnw) begin
            bus.region = ROM;                           // Reads only, writes fall through
        end else if (a[15:12] == BANK_PAGE && !bus.rnw) begin
            bus.region = BANK;
        end else if (a[15:13] == GFX1_VRAM_PAGE) begin
            bus.region = GFX1_VRAM;
        end else if (a[15:13] == GFX2_VRAM_PAGE) begin
            bus.region = GFX2_VRAM;
        end else if (a[15:12] == RAM_PAGE) begin
            bus.region = RAM;
        end else if (a[15:10] == PAL_PAGE) begin
            bus.region = PAL;
        end else if (a[15:10] == IO_PAGE) begin
            // A[9:8] not decoded, page mirrors
            if (bus.rnw)                      bus.region = IN;
            else if (a[7:3] == GFX1_CFG_ROW)  bus.region = GFX1_CFG;
            else if (a[7:3] == GFX2_CFG_ROW)  bus.region = GFX2_CFG;
            else if (a[7:3] == OUT_ROW)       bus.region = OUT;
            else                              bus.region = NONE;
        end else begin
            bus.region = NONE;
        end
    end

    // Fixed top half, or bank+4 in front of the 8kB window offset
    always_comb begin
        if (a[ADDR_W-1])
            rom_addr = {{(ROM_AW-DIRECT_W){1'b0}}, a[DIRECT_W-1:0]};
        else
            rom_addr = {bank + BANK_W'(BANK_BASE), a[BANK_OFS_W-1:0]};
    end

    assign rom_cs       = active && bus.region == ROM;
    assign ram_cs       = active && bus.region == RAM;
    assign pal_cs       = active && bus.region == PAL;
    assign gfx1_vram_cs = active && bus.region == GFX1_VRAM;
    assign gfx2_vram_cs = active && bus.region == GFX2_VRAM;
    assign gfx1_cfg_cs  = active && bus.region == GFX1_CFG;
    assign gfx2_cfg_cs  = active && bus.region == GFX2_CFG;

    // SDRAM needs the ROM address held for the whole access
    a_rom_addr_hold: assert property (@(posedge bus.clk)
        rom_cs && $past(rom_cs) |-> $stable(rom_addr))
        else $error("rom_addr changed during a ROM access");

endmodule

//--- verilog/cabinet_inputs.sv
/*
 * Cabinet input ports
 * Registers the addressed input port on an I/O page read,
 * with the board's joystick bit order and DIP padding
 */
`timescale 1ns/1ps

module cabinet_inputs import main_map_pkg::*, cabinet_pkg::*; (
    input  logic              clk,
    cpu_bus_if.io             bus,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  joy_t              joystick1,
    input  joy_t              joystick2,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic [3:0]        dipsw_c,
    output logic [DATA_W-1:0] port_in
);

    // Board wiring puts down/up then right/left in the low nibble
    function automatic logic [DATA_W-1:0] joy_port(input joy_t j);
        return {2'b11, j.buttons, j.down, j.up, j.right, j.left};
    endfunction

    // Sampled at the end of the strobe cycle, read back one cycle later
    always_ff @(posedge clk) begin
        if (bus.strobe && bus.region == IN) begin
            case (bus.addr[2:0])
                IN_SYS:  port_in <= {3'b111, start_button, service, coin_input};
                IN_P1:   port_in <= joy_port(joystick1);
                IN_P2:   port_in <= joy_port(joystick2);
                IN_DSWA: port_in <= dipsw_a;
                IN_DSWB: port_in <= dipsw_b;
                IN_DSWC: port_in <= {4'hf, dipsw_c};   // Upper switches not fitted
                default: ;                             // Offsets 3 and 7 hold last value
            endcase
        end
    end

endmodule

//--- verilog/io_latches.sv
/*
 * I/O page output registers
 * ROM bank register, sound latch and the sound CPU interrupt
 * pulse, written from bank and output strobes
 */
`timescale 1ns/1ps

module io_latches import main_map_pkg::*, cabinet_pkg::*; #(
    parameter int ROM_AW = 17
) (
    input  logic                         clk,
    input  logic                         rst,
    cpu_bus_if.io                        bus,
    output logic [ROM_AW-BANK_OFS_W-1:0] bank,
    output logic [DATA_W-1:0]            snd_latch,
    output logic                         snd_irq
);

    localparam int BANK_W = ROM_AW - BANK_OFS_W;

    logic bank_wr;
    logic out_wr;

    assign bank_wr = bus.strobe && bus.region == BANK;   // Region is write-only
    assign out_wr  = bus.strobe && bus.region == OUT;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= '0;
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else begin
            snd_irq <= 1'b0;                             // Pulse lasts one cycle
            if (bank_wr)
                bank <= bus.wdata[BANK_W-1:0];           // Low data bits only
            if (out_wr) begin
                case (bus.addr[2:1])
                    OUT_SND_IRQ:   snd_irq   <= 1'b1;
                    OUT_SND_LATCH: snd_latch <= bus.wdata;
                    default: ;                           // Coin counters, watchdog
                endcase
            end
        end
    end

endmodule

//--- verilog/main_bus_ctrl.sv
/*
 * Main CPU bus controller
 * Four-phase req/ack sequencer with ROM wait states, registered
 * read-data mux and the edge-triggered CPU interrupt flip-flop
 */
`timescale 1ns/1ps

module main_bus_ctrl import main_map_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // External bus master
    input  logic              bus_req,
    output logic              bus_ack,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic              bus_rnw,
    input  logic [DATA_W-1:0] bus_wdata,
    output logic [DATA_W-1:0] bus_rdata,
    // Read sources
    input  logic [DATA_W-1:0] rom_data,
    input  logic              rom_ok,
    input  logic [DATA_W-1:0] ram_dout,
    input  logic [DATA_W-1:0] pal_dout,
    input  logic [DATA_W-1:0] gfx1_dout,
    input  logic [DATA_W-1:0] gfx2_dout,
    input  logic [DATA_W-1:0] port_in,
    // Interrupt
    input  logic              gfx_irqn,
    input  logic              dip_pause,
    input  logic              irq_ack,
    output logic              irq_n,
    // Internal bus
    output logic              active,     // Chip selects enabled
    cpu_bus_if.ctrl           bus
);

    typedef enum logic [1:0] {IDLE, ACCESS, WAIT_ROM, ACK} state_t;

    state_t            state;
    logic              strobe_q;          // First cycle of ACCESS
    logic [ADDR_W-1:0] addr_q;
    logic              rnw_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rd_mux;
    logic              irq_trig;
    logic              irq_trig_q;

    assign bus.addr   = addr_q;
    assign bus.rnw    = rnw_q;
    assign bus.wdata  = wdata_q;
    assign bus.strobe = strobe_q;

    // Selects come up once the strobe cycle is over
    assign active = (state == ACCESS && !strobe_q) || state == WAIT_ROM;

    always_comb begin
        case (bus.region)
            ROM:       rd_mux = rom_data;
            RAM:       rd_mux = ram_dout;
            PAL:       rd_mux = pal_dout;
            IN:        rd_mux = port_in;     // Already registered on the strobe
            GFX1_VRAM: rd_mux = gfx1_dout;
            GFX2_VRAM: rd_mux = gfx2_dout;
            default:   rd_mux = OPEN_BUS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            strobe_q <= 1'b0;
            bus_ack  <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state)
                IDLE: if (bus_req) begin
                    state    <= ACCESS;
                    strobe_q <= 1'b1;
                end
                ACCESS: if (!strobe_q) begin
                    state   <= ACK;          // Data phase done
                    bus_ack <= 1'b1;
                end else if (bus.region == ROM) begin
                    state <= WAIT_ROM;       // SDRAM latency varies
                end
                WAIT_ROM: if (rom_ok) begin
                    state   <= ACK;
                    bus_ack <= 1'b1;
                end
                ACK: if (!bus_req) begin     // Master done, release
                    state   <= IDLE;
                    bus_ack <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request held stable by the master, sampled once
    always_ff @(posedge clk) begin
        if (state == IDLE && bus_req) begin
            addr_q  <= bus_addr;
            rnw_q   <= bus_rnw;
            wdata_q <= bus_wdata;
        end
        if ((state == ACCESS && !strobe_q) || (state == WAIT_ROM && rom_ok))
            bus_rdata <= rd_mux;             // Valid with bus_ack
    end

    // Vblank from the graphics chip or pause switch, rising edge sets
    assign irq_trig = ~gfx_irqn | dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_q <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_q <= irq_trig;
            if (irq_ack)
                irq_n <= 1'b1;               // Acknowledge wins
            else if (irq_trig && !irq_trig_q)
                irq_n <= 1'b0;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) |-> bus_req)
        else $error("bus_ack raised with no request pending");

    // ROM data only taken once the SDRAM reports it ready
    a_rom_wait: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_ack) && bus.region == ROM |-> $past(rom_ok))
        else $error("ROM read acknowledged without rom_ok");

endmodule

//--- verilog/contra_main.sv
/*
 * Main CPU section glue
 * Bus controller, address decoder, cabinet inputs and output
 * latches around an external four-phase bus master
 */
`timescale 1ns/1ps

module contra_main import main_map_pkg::*; #(
    parameter int ROM_AW = 17
) (
    input  logic              clk,
    input  logic              rst,
    // Bus master
    input  logic              bus_req,
    output logic              bus_ack,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic              bus_rnw,
    input  logic [DATA_W-1:0] bus_wdata,
    output logic [DATA_W-1:0] bus_rdata,
    // ROM
    output logic [ROM_AW-1:0] rom_addr,
    output logic              rom_cs,
    input  logic [DATA_W-1:0] rom_data,
    input  logic              rom_ok,
    // Work RAM, palette and graphics
    output logic              ram_cs,
    input  logic [DATA_W-1:0] ram_dout,
    output logic              pal_cs,
    input  logic [DATA_W-1:0] pal_dout,
    output logic              gfx1_vram_cs,
    output logic              gfx2_vram_cs,
    output logic              gfx1_cfg_cs,
    output logic              gfx2_cfg_cs,
    input  logic [DATA_W-1:0] gfx1_dout,
    input  logic [DATA_W-1:0] gfx2_dout,
    input  logic              gfx_irqn,
    // Cabinet
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic [5:0]        joystick1,
    input  logic [5:0]        joystick2,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic [3:0]        dipsw_c,
    input  logic              dip_pause,
    // CPU interrupt
    input  logic              irq_ack,
    output logic              irq_n,
    // Sound CPU
    output logic [DATA_W-1:0] snd_latch,
    output logic              snd_irq
);

    logic [ROM_AW-BANK_OFS_W-1:0] bank;
    logic [DATA_W-1:0]            port_in;
    logic                         active;

    cpu_bus_if bus (.clk(clk));

    main_bus_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_ack   (bus_ack),
        .bus_addr  (bus_addr),
        .bus_rnw   (bus_rnw),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .gfx1_dout (gfx1_dout),
        .gfx2_dout (gfx2_dout),
        .port_in   (port_in),
        .gfx_irqn  (gfx_irqn),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .irq_n     (irq_n),
        .active    (active),
        .bus       (bus.ctrl)
    );

    addr_decoder #(.ROM_AW(ROM_AW)) i_dec (
        .bus          (bus.dec),
        .active       (active),
        .bank         (bank),
        .rom_addr     (rom_addr),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .pal_cs       (pal_cs),
        .gfx1_vram_cs (gfx1_vram_cs),
        .gfx2_vram_cs (gfx2_vram_cs),
        .gfx1_cfg_cs  (gfx1_cfg_cs),
        .gfx2_cfg_cs  (gfx2_cfg_cs)
    );

    cabinet_inputs i_inputs (
        .clk          (clk),
        .bus          (bus.io),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .joystick1    (joystick1),   // Packed into the joystick record
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .port_in      (port_in)
    );

    io_latches #(.ROM_AW(ROM_AW)) i_latches (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.io),
        .bank      (bank),
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq)
    );

endmodule

//--- verification/contra_main_tb.sv
/*
 * Testbench for the main CPU section glue
 * Replays bus operations from the input file, models ROM with
 * random wait states and the graphics and palette read ports
 */
`timescale 1ns/1ps

module contra_main_tb import main_map_pkg::*; ();

    localparam int ROM_AW     = 17;
    localparam int NAME_W     = 8 * 24;
    localparam int WAIT_LIMIT = 50;           // Cycles per wait loop

    logic              clk;
    logic              rst;
    logic              bus_req;
    logic              bus_ack;
    logic [ADDR_W-1:0] bus_addr;
    logic              bus_rnw;
    logic [DATA_W-1:0] bus_wdata;
    logic [DATA_W-1:0] bus_rdata;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic [DATA_W-1:0] rom_data = '0;
    logic              rom_ok = 1'b0;
    logic              ram_cs, pal_cs, gfx1_vram_cs, gfx2_vram_cs, gfx1_cfg_cs, gfx2_cfg_cs;
    logic [DATA_W-1:0] ram_dout, pal_dout, gfx1_dout, gfx2_dout;
    logic              gfx_irqn;
    logic [1:0]        start_button, coin_input;
    logic              service;
    logic [5:0]        joystick1, joystick2;
    logic [7:0]        dipsw_a, dipsw_b;
    logic [3:0]        dipsw_c;
    logic              dip_pause, irq_ack, irq_n;
    logic [DATA_W-1:0] snd_latch;
    logic              snd_irq;

    // ROM model state
    logic        rom_busy = 1'b0;
    logic [1:0]  rom_delay = '0;
    logic [31:0] lfsr_state = 32'hae7d;

    // Observations of the current access
    logic [6:0]        cs_mask;
    logic [ROM_AW-1:0] rom_addr_seen;
    logic              rom_ok_seen;
    logic [DATA_W-1:0] got_rdata;
    int                irq_pulses;
    int                errors;
    int                timeouts;

    contra_main #(.ROM_AW(ROM_AW)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // Data is address low byte XOR A5, ready 0-3 cycles after select
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (!rom_busy) begin
            rom_busy  <= 1'b1;
            rom_data  <= rom_addr[7:0] ^ 8'ha5;
            rom_delay <= {lfsr_bit(), lfsr_bit()};
        end else if (rom_delay == 2'd0) begin
            rom_ok <= 1'b1;
        end else begin
            rom_delay <= rom_delay - 2'd1;
        end
    end

    function automatic logic [6:0] cs_vector();
        return {rom_cs, ram_cs, pal_cs, gfx1_vram_cs, gfx2_vram_cs, gfx1_cfg_cs, gfx2_cfg_cs};
    endfunction

    // Top half, or 6000-7FFF when reading
    function automatic logic is_rom_read(input logic [ADDR_W-1:0] a);
        return a[15] || a[15:13] == 3'b011;
    endfunction

    // Selects expected for a write, same bit order as cs_vector
    function automatic logic [6:0] write_selects(input logic [ADDR_W-1:0] a);
        if (a[15] || a[15:12] == 4'h7)
            return 7'd0;                     // ROM space or bank register
        if (a[15:13] == 3'b001)
            return 7'b0001000;
        if (a[15:13] == 3'b010)
            return 7'b0000100;
        if (a[15:12] == 4'h1)
            return 7'b0100000;
        if (a[15:10] == 6'b000011)
            return 7'b0010000;
        if (a[15:10] == 6'd0 && a[7:3] == 5'b00000)
            return 7'b0000010;               // Config of the first graphics chip
        if (a[15:10] == 6'd0 && a[7:3] == 5'b01100)
            return 7'b0000001;
        return 7'd0;
    endfunction

    // I/O page row 18-1F, register 1 on A[2:1]
    function automatic logic is_snd_irq_write(input logic [ADDR_W-1:0] a);
        return a[15:10] == 6'd0 && a[7:3] == 5'b00011 && a[2:1] == 2'b01;
    endfunction

    task automatic check_value(input logic [NAME_W-1:0] name, input string what,
                               input logic [23:0] exp, input logic [23:0] got);
        assert (got == exp) else begin
            $display("error %0s %0s: expected %h, got %h", name, what, exp, got);
            errors++;
        end
    endtask

    // Stimulus word: dswa dswb dswc joy2 joy1 start coin service pause vblank
    task automatic drive_inputs(input logic [39:0] stim);
        dipsw_a      <= stim[39:32];
        dipsw_b      <= stim[31:24];
        dipsw_c      <= stim[23:20];
        joystick2    <= stim[19:14];
        joystick1    <= stim[13:8];
        start_button <= stim[7:6];
        coin_input   <= stim[5:4];
        service      <= stim[3];
        dip_pause    <= stim[2];
        gfx_irqn     <= ~stim[1];           // Vblank is active low
    endtask

    // Full four-phase cycle, observing selects until ack
    task automatic bus_cycle(input logic rnw, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [39:0] stim,
                             input logic [NAME_W-1:0] name);
        int cnt;
        cs_mask     = '0;
        rom_ok_seen = 1'b0;
        irq_pulses  = 0;
        @(posedge clk);
        drive_inputs(stim);
        bus_req   <= 1'b1;
        bus_addr  <= addr;
        bus_rnw   <= rnw;
        bus_wdata <= wdata;
        cnt = 0;
        @(negedge clk);
        while (!bus_ack && cnt < WAIT_LIMIT) begin
            cs_mask = cs_mask | cs_vector();
            if (rom_cs) begin
                rom_addr_seen = rom_addr;
                rom_ok_seen   = rom_ok_seen | rom_ok;
            end
            if (snd_irq)
                irq_pulses++;
            @(negedge clk);
            cnt++;
        end
        if (!bus_ack) begin
            $display("timeout: no bus_ack for %0s", name);
            timeouts++;
            return;
        end
        got_rdata = bus_rdata;
        repeat (2) begin                     // Master stalls, ack must hold
            @(negedge clk);
            check_value(name, "ack hold", 24'd1, 24'(bus_ack));
            if (snd_irq)
                irq_pulses++;
        end
        @(posedge clk);
        bus_req <= 1'b0;
        @(negedge clk);
        check_value(name, "ack after req drop", 24'd1, 24'(bus_ack));
        cnt = 0;
        while (bus_ack && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (bus_ack) begin
            $display("timeout: bus_ack stuck high after %0s", name);
            timeouts++;
        end
    endtask

    task automatic interrupt_check(input logic [39:0] stim, input logic exp_level,
                                   input logic [NAME_W-1:0] name);
        int cnt;
        @(posedge clk);
        drive_inputs(stim);                  // Raise vblank or pause
        cnt = 0;
        @(negedge clk);
        while (irq_n && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (irq_n) begin
            $display("timeout: irq_n never fell for %0s", name);
            timeouts++;
            return;
        end
        repeat (3) begin                     // Latched until acknowledged
            @(negedge clk);
            check_value(name, "irq_n held", 24'(exp_level), 24'(irq_n));
        end
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        check_value(name, "irq_n after ack", 24'd1, 24'(irq_n));
        @(posedge clk);
        drive_inputs(40'd0);
        @(negedge clk);
        check_value(name, "irq_n released", 24'd1, 24'(irq_n));   // Falling source ignored
    endtask

    task automatic run_line(input logic [7:0] op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [39:0] stim,
                            input logic [23:0] expv, input logic [NAME_W-1:0] name);
        int exp_pulses;
        if (op == "I") begin
            interrupt_check(stim, expv[0], name);
        end else if (op == "R" || op == "W") begin
            bus_cycle(op == "R", addr, wdata, stim, name);
            if (timeouts == 0) begin
                if (op == "W") begin
                    exp_pulses = is_snd_irq_write(addr) ? 1 : 0;
                    check_value(name, "snd_latch", {16'd0, expv[7:0]}, {16'd0, snd_latch});
                    check_value(name, "snd_irq cycles", 24'(exp_pulses), 24'(irq_pulses));
                    check_value(name, "selects", {17'd0, write_selects(addr)},
                                {17'd0, cs_mask});
                end else if (is_rom_read(addr)) begin
                    check_value(name, "rom_addr", {7'd0, expv[16:0]}, {7'd0, rom_addr_seen});
                    check_value(name, "rdata", {16'd0, expv[7:0] ^ 8'ha5}, {16'd0, got_rdata});
                    check_value(name, "selects", 24'h40, {17'd0, cs_mask});
                    assert (rom_ok_seen) else begin
                        $display("ROM read %0s was acknowledged before rom_ok", name);
                        errors++;
                    end
                end else begin
                    check_value(name, "rdata", {16'd0, expv[7:0]}, {16'd0, got_rdata});
                    check_value(name, "selects", {17'd0, expv[14:8]}, {17'd0, cs_mask});
                end
            end
        end else begin
            $display("unknown operation %c in stimulus file", op);
            errors++;
        end
    endtask

    initial begin
        int                fd;
        int                code;
        logic              done;
        logic [7:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [39:0]       stim;
        logic [23:0]       expv;
        logic [NAME_W-1:0] name;
        logic [8*200-1:0]  skip_line;
        errors    = 0;
        timeouts  = 0;
        rst       = 1'b1;
        bus_req   = 1'b0;
        bus_addr  = '0;
        bus_rnw   = 1'b1;
        bus_wdata = '0;
        ram_dout  = 8'h3c;                   // Distinct per source
        pal_dout  = 8'h5d;
        gfx1_dout = 8'h71;
        gfx2_dout = 8'h92;
        gfx_irqn  = 1'b1;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        joystick1    = '0;
        joystick2    = '0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        dipsw_c      = '0;
        dip_pause    = 1'b0;
        irq_ack      = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset", "bus_ack", 24'd0, 24'(bus_ack));
        check_value("reset", "selects", 24'd0, {17'd0, cs_vector()});
        check_value("reset", "irq_n", 24'd1, 24'(irq_n));
        check_value("reset", "snd_irq", 24'd0, 24'(snd_irq));
        check_value("reset", "snd_latch", 24'd0, {16'd0, snd_latch});
        fd = $fopen("verification/contra_main_input.txt", "r");
        done = (fd == 0);
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(skip_line, fd);    // Column notes
            end else begin
                code = $fscanf(fd, "%h %h %h %h %s", addr, wdata, stim, expv, name);
                if (code != 5) begin
                    $display("malformed line in the stimulus file");
                    errors++;
                    done = 1'b1;
                end else begin
                    run_line(op, addr, wdata, stim, expv, name);
                    done = (timeouts != 0);      // Bus state unknown after a timeout
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verification/contra_main_input.txt
# op addr wdata stim(dswa dswb dswc joy2 joy1 start coin service pause vblank) expected name
# R: ROM reads expect rom_addr, other reads {selects rom ram pal v1 v2 c1 c2, data}
# W: expected snd_latch afterwards   I: expected irq_n while the source is held
R 0000 00 5ac3699998 0000f5 in_sys
R 0001 00 5ac3699998 0000d6 in_p1
R 0002 00 5ac3699998 0000e9 in_p2
R 0004 00 5ac3699998 00005a in_dswa
R 0005 00 5ac3699998 0000c3 in_dswb
R 0006 00 5ac3699998 0000f6 in_dswc
R 0300 00 0000000000 0000e0 in_sys_mirror
R 0006 00 0000000000 0000f0 in_dswc_zero
W 7000 03 0000000000 000000 bank_3
R 6123 00 0000000000 00e123 rom_bank_3
W 7fff 1a 0000000000 000000 bank_a
R 7abc 00 0000000000 01dabc rom_bank_a
W 7000 0d 0000000000 000000 bank_d
R 6000 00 0000000000 002000 rom_bank_wrap
R 8000 00 0000000000 000000 rom_top_low
R f5a7 00 0000000000 0075a7 rom_top
W 001c 5e 0000000000 00005e snd_latch
W 0018 33 0000000000 00005e coin_ignored
W 001a 00 0000000000 00005e snd_irq
W 001d c1 0000000000 0000c1 snd_latch_mirror
R 0c10 00 0000000000 00105d palette
R 1234 00 0000000000 00203c work_ram
R 2345 00 0000000000 000871 gfx1_vram
R 4567 00 0000000000 000492 gfx2_vram
R 0800 00 0000000000 0000ff unmapped
W 0004 12 0000000000 0000c1 gfx1_cfg_write
I 0000 00 0000000002 000000 irq_vblank
I 0000 00 0000000004 000000 irq_pause

//--- contra_main.f
verilog/main_map_pkg.sv
verilog/cabinet_pkg.sv
verilog/cpu_bus_if.sv
verilog/addr_decoder.sv
verilog/cabinet_inputs.sv
verilog/io_latches.sv
verilog/main_bus_ctrl.sv
verilog/contra_main.sv
verification/contra_main_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the contra_main testbench with Verilator and run it
# Exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module contra_main_tb \
    -Mdir obj_dir \
    -f contra_main.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcontra_main_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
